// ==== design/ethernet_pkg.sv ====
package ethernet_pkg;

    // Type field of an Ethernet II frame carrying IPv4
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    // Destination, source and type
    localparam int MAC_HEADER_BYTES = 14;

    localparam int FCS_BYTES = 4;

    // Shortest UDP data field that still fills a 64 byte frame
    localparam int MIN_UDP_DATA_BYTES = 18;

    ////////////////////////////////////////////////////////////
    // Frame check sequence
    ////////////////////////////////////////////////////////////

    // Reflected form of 0x04C11DB7, data shifted in LSB first
    localparam logic [31:0] CRC32_POLYNOMIAL = 32'hEDB88320;
    localparam logic [31:0] CRC32_INITIAL = 32'hFFFFFFFF;

endpackage

// ==== design/ipv4_udp_pkg.sv ====
package ipv4_udp_pkg;

    ////////////////////////////////////////////////////////////
    // IPv4 header fields
    ////////////////////////////////////////////////////////////

    // Version 4, five 32-bit header words
    localparam logic [7:0] IPV4_VERSION_IHL = 8'h45;
    localparam logic [7:0] IPV4_DSCP = 8'h00;
    localparam logic [7:0] IPV4_TIME_TO_LIVE = 8'h80;
    localparam logic [7:0] IPV4_PROTOCOL_UDP = 8'h11;

    localparam int IPV4_HEADER_BYTES = 20;
    localparam int IPV4_HEADER_WORDS = 10;

    ////////////////////////////////////////////////////////////
    // UDP
    ////////////////////////////////////////////////////////////

    localparam int UDP_HEADER_BYTES = 8;

    // Payload buffer depth seen by the generator
    localparam int BUFFER_ADDRESS_WIDTH = 16;

endpackage

// ==== design/ipv4_header_checksum.sv ====
`timescale 1ns/10ps

module ipv4_header_checksum (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        checksum_start,
    input  logic [15:0] ipv4_total_length,
    input  logic [15:0] ipv4_identification,
    input  logic [31:0] ipv4_source,
    input  logic [31:0] ipv4_destination,
    output logic [15:0] header_checksum,
    output logic        checksum_done
);
    import ipv4_udp_pkg::*;

    logic [3:0]  word_index;
    logic [15:0] header_word;
    logic [15:0] carried_sum;
    logic [16:0] running_sum;
    logic [16:0] accumulator;
    logic        last_word;

    // Header words in transmit order
    always_comb begin
        case (word_index)
            4'd0: header_word = {IPV4_VERSION_IHL, IPV4_DSCP};
            4'd1: header_word = ipv4_total_length;
            4'd2: header_word = ipv4_identification;
            4'd4: header_word = {IPV4_TIME_TO_LIVE, IPV4_PROTOCOL_UDP};
            4'd6: header_word = ipv4_source[31:16];
            4'd7: header_word = ipv4_source[15:0];
            4'd8: header_word = ipv4_destination[31:16];
            4'd9: header_word = ipv4_destination[15:0];
            // Flags, fragment offset and the checksum field itself
            default: header_word = 16'h0000;
        endcase
    end

    // End-around carry of the previous word folded back in
    assign carried_sum = checksum_start ? 16'h0000 : accumulator[15:0] + 16'(accumulator[16]);
    assign running_sum = {1'b0, carried_sum} + {1'b0, header_word};
    assign last_word = word_index == 4'(IPV4_HEADER_WORDS - 1);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            word_index <= '0;
            checksum_done <= 1'b0;
        end else begin
            checksum_done <= 1'b0;
            if (checksum_start) begin
                word_index <= 4'd1;
            end else if (last_word) begin
                word_index <= '0;
                checksum_done <= 1'b1;
            end else if (word_index != '0) begin
                word_index <= word_index + 4'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        accumulator <= running_sum;
        if (last_word) begin
            header_checksum <= ~(running_sum[15:0] + 16'(running_sum[16]));
        end
    end

endmodule

// ==== design/frame_sequencer.sv ====
`timescale 1ns/10ps

module frame_sequencer #(
    parameter int unsigned INTER_PACKET_GAP_CYCLES = 15
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        enable,
    input  logic [47:0] mac_destination,
    input  logic [47:0] mac_source,
    input  logic [31:0] ipv4_source,
    input  logic [31:0] ipv4_destination,
    input  logic [15:0] ipv4_identification,
    input  logic [15:0] udp_source,
    input  logic [15:0] udp_destination,
    input  logic [15:0] udp_payload_size,
    input  logic [7:0]  udp_buffer_read_data,
    input  logic        checksum_done,
    input  logic [15:0] header_checksum,
    output logic        ready,
    output logic [ipv4_udp_pkg::BUFFER_ADDRESS_WIDTH-1:0] udp_buffer_read_address,
    output logic        checksum_start,
    output logic [15:0] ipv4_total_length,
    output logic [15:0] saved_ipv4_identification,
    output logic [31:0] saved_ipv4_source,
    output logic [31:0] saved_ipv4_destination,
    output logic [7:0]  byte_data,
    output logic        byte_valid,
    output logic        byte_first,
    output logic        byte_end
);
    import ethernet_pkg::*;
    import ipv4_udp_pkg::*;

    localparam int HEADER_BYTES = MAC_HEADER_BYTES + IPV4_HEADER_BYTES + UDP_HEADER_BYTES;
    localparam logic [15:0] GAP_END = 16'(FCS_BYTES + INTER_PACKET_GAP_CYCLES);

    localparam logic [2:0] S_IDLE          = 3'd0;
    localparam logic [2:0] S_CHECKSUM_WAIT = 3'd1;
    localparam logic [2:0] S_HEADER        = 3'd2;
    localparam logic [2:0] S_PAYLOAD       = 3'd3;
    localparam logic [2:0] S_PAD           = 3'd4;
    localparam logic [2:0] S_GAP           = 3'd5;

    logic [2:0]                  state;
    logic [15:0]                 byte_counter;
    logic [47:0]                 saved_mac_destination;
    logic [47:0]                 saved_mac_source;
    logic [15:0]                 saved_udp_source;
    logic [15:0]                 saved_udp_destination;
    logic [15:0]                 saved_udp_payload_size;
    logic [15:0]                 udp_length;
    logic [HEADER_BYTES*8-1:0]   header_vector;
    logic [7:0]                  header_byte;
    logic                        last_header_byte;
    logic                        last_payload_byte;
    logic                        needs_pad;

    ////////////////////////////////////////////////////////////
    // Header byte selection
    ////////////////////////////////////////////////////////////

    // Flags, fragment offset and UDP checksum go out as zero
    assign header_vector = {
        saved_mac_destination, saved_mac_source, ETHERTYPE_IPV4,
        IPV4_VERSION_IHL, IPV4_DSCP, ipv4_total_length,
        saved_ipv4_identification, 16'h0000,
        IPV4_TIME_TO_LIVE, IPV4_PROTOCOL_UDP, header_checksum,
        saved_ipv4_source, saved_ipv4_destination,
        saved_udp_source, saved_udp_destination, udp_length, 16'h0000
    };

    // First byte sits in the top bits
    assign header_byte = header_vector[8*(HEADER_BYTES-1-int'(byte_counter)) +: 8];

    assign last_header_byte = byte_counter == 16'(HEADER_BYTES - 1);
    assign last_payload_byte = byte_counter == saved_udp_payload_size - 16'd1;
    assign needs_pad = saved_udp_payload_size < 16'(MIN_UDP_DATA_BYTES);

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= S_IDLE;
            byte_counter <= '0;
            ready <= 1'b0;
            checksum_start <= 1'b0;
            udp_buffer_read_address <= '0;
            byte_valid <= 1'b0;
            byte_first <= 1'b0;
            byte_end <= 1'b0;
        end else begin
            checksum_start <= 1'b0;
            byte_first <= 1'b0;
            byte_end <= 1'b0;
            case (state)
                S_IDLE: begin
                    ready <= 1'b1;
                    byte_counter <= '0;
                    udp_buffer_read_address <= '0;
                    if (ready && enable) begin
                        ready <= 1'b0;
                        checksum_start <= 1'b1;
                        state <= S_CHECKSUM_WAIT;
                    end
                end
                S_CHECKSUM_WAIT: begin
                    if (checksum_done) begin
                        byte_valid <= 1'b1;
                        byte_first <= 1'b1;
                        byte_counter <= 16'd1;
                        state <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    byte_counter <= byte_counter + 16'd1;
                    if (last_header_byte) begin
                        // Read of byte 1 goes out while byte 0 returns
                        byte_counter <= '0;
                        udp_buffer_read_address <= udp_buffer_read_address + 1'b1;
                        state <= (saved_udp_payload_size == '0) ? S_PAD : S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    byte_counter <= byte_counter + 16'd1;
                    udp_buffer_read_address <= udp_buffer_read_address + 1'b1;
                    if (last_payload_byte) begin
                        if (needs_pad) begin
                            state <= S_PAD;
                        end else begin
                            byte_end <= 1'b1;
                            byte_counter <= '0;
                            state <= S_GAP;
                        end
                    end
                end
                S_PAD: begin
                    byte_counter <= byte_counter + 16'd1;
                    if (byte_counter == 16'(MIN_UDP_DATA_BYTES - 1)) begin
                        byte_end <= 1'b1;
                        byte_counter <= '0;
                        state <= S_GAP;
                    end
                end
                S_GAP: begin
                    // FCS bytes leave downstream before the gap proper
                    byte_valid <= 1'b0;
                    byte_counter <= byte_counter + 16'd1;
                    if (byte_counter == GAP_END) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Field capture and output byte
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (state == S_IDLE) begin
            saved_mac_destination <= mac_destination;
            saved_mac_source <= mac_source;
            saved_ipv4_source <= ipv4_source;
            saved_ipv4_destination <= ipv4_destination;
            saved_ipv4_identification <= ipv4_identification;
            saved_udp_source <= udp_source;
            saved_udp_destination <= udp_destination;
            saved_udp_payload_size <= udp_payload_size;
            ipv4_total_length <= udp_payload_size + 16'(IPV4_HEADER_BYTES + UDP_HEADER_BYTES);
            udp_length <= udp_payload_size + 16'(UDP_HEADER_BYTES);
        end

        case (state)
            S_CHECKSUM_WAIT, S_HEADER: byte_data <= header_byte;
            S_PAYLOAD: byte_data <= udp_buffer_read_data;
            default: byte_data <= 8'h00;
        endcase
    end

endmodule

// ==== design/frame_check_sequence.sv ====
`timescale 1ns/10ps

module frame_check_sequence (
    input  logic       clock,
    input  logic       reset_n,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    input  logic       byte_first,
    input  logic       byte_end,
    output logic [7:0] frame_data,
    output logic       frame_valid,
    output logic       frame_start,
    output logic       frame_last
);
    import ethernet_pkg::*;

    logic [31:0] crc;
    logic [31:0] crc_seed;
    logic [2:0]  fcs_remaining;

    // One byte of reflected CRC-32, bit 0 first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] value;
        value = crc_in ^ {24'h000000, data};
        for (int bit_index = 0; bit_index < 8; bit_index++) begin
            if (value[0]) begin
                value = (value >> 1) ^ CRC32_POLYNOMIAL;
            end else begin
                value = value >> 1;
            end
        end
        return value;
    endfunction

    assign crc_seed = byte_first ? CRC32_INITIAL : crc;

    ////////////////////////////////////////////////////////////
    // Strobes and FCS byte count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            frame_valid <= 1'b0;
            frame_start <= 1'b0;
            frame_last <= 1'b0;
            fcs_remaining <= '0;
        end else begin
            frame_start <= byte_valid && byte_first;
            if (fcs_remaining != '0) begin
                frame_valid <= 1'b1;
                frame_last <= fcs_remaining == 3'd1;
                fcs_remaining <= fcs_remaining - 3'd1;
            end else begin
                frame_valid <= byte_valid;
                frame_last <= 1'b0;
                if (byte_valid && byte_end) begin
                    fcs_remaining <= 3'(FCS_BYTES);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (fcs_remaining != '0) begin
            // Inverted remainder, low byte on the wire first
            frame_data <= ~crc[7:0];
            crc <= crc >> 8;
        end else begin
            frame_data <= byte_data;
            if (byte_valid) begin
                crc <= crc32_byte(crc_seed, byte_data);
            end
        end
    end

endmodule

// ==== design/udp_frame_generator.sv ====
`timescale 1ns/10ps

module udp_frame_generator #(
    parameter int unsigned INTER_PACKET_GAP_CYCLES = 15
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        enable,
    input  logic [47:0] mac_destination,
    input  logic [47:0] mac_source,
    input  logic [31:0] ipv4_source,
    input  logic [31:0] ipv4_destination,
    input  logic [15:0] ipv4_identification,
    input  logic [15:0] udp_source,
    input  logic [15:0] udp_destination,
    input  logic [15:0] udp_payload_size,
    input  logic [7:0]  udp_buffer_read_data,
    output logic [ipv4_udp_pkg::BUFFER_ADDRESS_WIDTH-1:0] udp_buffer_read_address,
    output logic [7:0]  frame_data,
    output logic        frame_valid,
    output logic        frame_start,
    output logic        frame_last,
    output logic        ready
);

    // Sequencer to checksum
    logic        checksum_start;
    logic        checksum_done;
    logic [15:0] header_checksum;
    logic [15:0] ipv4_total_length;
    logic [15:0] saved_ipv4_identification;
    logic [31:0] saved_ipv4_source;
    logic [31:0] saved_ipv4_destination;

    // Sequencer to FCS
    logic [7:0]  byte_data;
    logic        byte_valid;
    logic        byte_first;
    logic        byte_end;

    frame_sequencer #(
        .INTER_PACKET_GAP_CYCLES (INTER_PACKET_GAP_CYCLES)
    ) frame_sequencer_i (
        .clock                     (clock),
        .reset_n                   (reset_n),
        .enable                    (enable),
        .mac_destination           (mac_destination),
        .mac_source                (mac_source),
        .ipv4_source               (ipv4_source),
        .ipv4_destination          (ipv4_destination),
        .ipv4_identification       (ipv4_identification),
        .udp_source                (udp_source),
        .udp_destination           (udp_destination),
        .udp_payload_size          (udp_payload_size),
        .udp_buffer_read_data      (udp_buffer_read_data),
        .checksum_done             (checksum_done),
        .header_checksum           (header_checksum),
        .ready                     (ready),
        .udp_buffer_read_address   (udp_buffer_read_address),
        .checksum_start            (checksum_start),
        .ipv4_total_length         (ipv4_total_length),
        .saved_ipv4_identification (saved_ipv4_identification),
        .saved_ipv4_source         (saved_ipv4_source),
        .saved_ipv4_destination    (saved_ipv4_destination),
        .byte_data                 (byte_data),
        .byte_valid                (byte_valid),
        .byte_first                (byte_first),
        .byte_end                  (byte_end)
    );

    ipv4_header_checksum ipv4_header_checksum_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .checksum_start      (checksum_start),
        .ipv4_total_length   (ipv4_total_length),
        .ipv4_identification (saved_ipv4_identification),
        .ipv4_source         (saved_ipv4_source),
        .ipv4_destination    (saved_ipv4_destination),
        .header_checksum     (header_checksum),
        .checksum_done       (checksum_done)
    );

    frame_check_sequence frame_check_sequence_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .byte_data   (byte_data),
        .byte_valid  (byte_valid),
        .byte_first  (byte_first),
        .byte_end    (byte_end),
        .frame_data  (frame_data),
        .frame_valid (frame_valid),
        .frame_start (frame_start),
        .frame_last  (frame_last)
    );

endmodule

// ==== testbench/udp_frame_generator_properties.sv ====
`timescale 1ns/10ps

module udp_frame_generator_properties #(
    parameter int unsigned INTER_PACKET_GAP_CYCLES = 15
) (
    input logic clock,
    input logic reset_n,
    input logic enable,
    input logic ready,
    input logic frame_valid,
    input logic frame_start,
    input logic frame_last
);

    int unsigned failure_count = 0;
    logic        frame_seen;

    // First rise of ready follows reset and not a frame
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            frame_seen <= 1'b0;
        end else if (frame_start) begin
            frame_seen <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stream
    ////////////////////////////////////////////////////////////

    start_with_valid: assert property (@(posedge clock) disable iff (!reset_n)
        frame_start |-> frame_valid)
    else begin
        failure_count++;
        $error("frame_start seen without frame_valid");
    end

    valid_opens_with_start: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(frame_valid) |-> frame_start)
    else begin
        failure_count++;
        $error("frame_valid rose without frame_start");
    end

    valid_held_to_last: assert property (@(posedge clock) disable iff (!reset_n)
        frame_valid && !frame_last |=> frame_valid)
    else begin
        failure_count++;
        $error("frame_valid dropped before frame_last");
    end

    valid_drops_after_last: assert property (@(posedge clock) disable iff (!reset_n)
        frame_last |=> !frame_valid)
    else begin
        failure_count++;
        $error("frame_valid still high after frame_last");
    end

    ////////////////////////////////////////////////////////////
    // Ready and inter-packet gap
    ////////////////////////////////////////////////////////////

    ready_drops_on_accept: assert property (@(posedge clock) disable iff (!reset_n)
        ready && enable |=> !ready)
    else begin
        failure_count++;
        $error("ready stayed high after a frame was accepted");
    end

    ready_low_in_frame: assert property (@(posedge clock) disable iff (!reset_n)
        frame_valid |-> !ready)
    else begin
        failure_count++;
        $error("ready high while a frame is on the output");
    end

    ready_rises_after_gap: assert property (@(posedge clock) disable iff (!reset_n)
        frame_last |-> ##(INTER_PACKET_GAP_CYCLES + 1) $rose(ready))
    else begin
        failure_count++;
        $error("ready did not rise at the end of the inter-packet gap");
    end

    ready_rises_only_after_gap: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(ready) && frame_seen |-> $past(frame_last, INTER_PACKET_GAP_CYCLES + 1))
    else begin
        failure_count++;
        $error("ready rose before the inter-packet gap ended");
    end

endmodule

// ==== testbench/udp_frame_generator_tb.sv ====
`timescale 1ns/10ps

module udp_frame_generator_tb;
    import ethernet_pkg::*;
    import ipv4_udp_pkg::*;

    localparam int unsigned INTER_PACKET_GAP_CYCLES = 15;
    localparam int FRAME_COUNT = 12;
    localparam logic [15:0] LFSR_SEED = 16'd53;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;
    localparam int HEADER_BYTES = MAC_HEADER_BYTES + IPV4_HEADER_BYTES + UDP_HEADER_BYTES;
    localparam int CHECKSUM_OFFSET = MAC_HEADER_BYTES + 10;
    localparam int START_DELAY_CYCLES = 13;
    localparam int MAX_FRAME_BYTES = 128;
    // Longest frame with 40 payload bytes, then the gap and some slack
    localparam int TIMEOUT_CYCLES = FRAME_COUNT * (13 + 86 + INTER_PACKET_GAP_CYCLES + 8) + 64;

    logic        clock = 1'b0;
    logic        reset_n = 1'b0;
    logic        enable = 1'b0;
    logic [47:0] mac_destination = '0;
    logic [47:0] mac_source = '0;
    logic [31:0] ipv4_source = '0;
    logic [31:0] ipv4_destination = '0;
    logic [15:0] ipv4_identification = '0;
    logic [15:0] udp_source = '0;
    logic [15:0] udp_destination = '0;
    logic [15:0] udp_payload_size = '0;
    logic [7:0]  udp_buffer_read_data = '0;
    logic [BUFFER_ADDRESS_WIDTH-1:0] udp_buffer_read_address;
    logic [7:0]  frame_data;
    logic        frame_valid;
    logic        frame_start;
    logic        frame_last;
    logic        ready;

    logic [15:0] lfsr_state = LFSR_SEED;
    int          cycle_count = 0;
    int          accept_cycle = 0;
    int          accepted_count = 0;
    int          frames_checked = 0;
    int          error_count = 0;
    int          frame_length = 0;
    int          header_fill = 0;
    logic [7:0]  frame_bytes [0:MAX_FRAME_BYTES-1];
    logic [7:0]  expected_header [0:HEADER_BYTES-1];

    // Fields as captured at the accepting edge
    logic [47:0] expected_mac_destination;
    logic [47:0] expected_mac_source;
    logic [31:0] expected_ipv4_source;
    logic [31:0] expected_ipv4_destination;
    logic [15:0] expected_ipv4_identification;
    logic [15:0] expected_udp_source;
    logic [15:0] expected_udp_destination;
    logic [15:0] expected_payload_size;

    udp_frame_generator #(
        .INTER_PACKET_GAP_CYCLES (INTER_PACKET_GAP_CYCLES)
    ) udp_frame_generator_i (.*);

    bind udp_frame_generator udp_frame_generator_properties #(
        .INTER_PACKET_GAP_CYCLES (INTER_PACKET_GAP_CYCLES)
    ) udp_frame_generator_properties_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .enable      (enable),
        .ready       (ready),
        .frame_valid (frame_valid),
        .frame_start (frame_start),
        .frame_last  (frame_last)
    );

    always #4 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int bit_index = 0; bit_index < count; bit_index++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
            value = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [7:0] buffer_byte(input logic [15:0] address);
        return address[7:0] ^ address[15:8];
    endfunction

    function automatic logic [31:0] crc32_update(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] crc_out;
        logic        feedback;
        crc_out = crc_in;
        for (int bit_index = 0; bit_index < 8; bit_index++) begin
            feedback = crc_out[0] ^ data[bit_index];
            crc_out = (crc_out >> 1) ^ (feedback ? CRC32_POLYNOMIAL : 32'h0);
        end
        return crc_out;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected) else begin
            error_count++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic draw_fields();
        mac_destination <= 48'(random_bits(48));
        mac_source <= 48'(random_bits(48));
        ipv4_source <= 32'(random_bits(32));
        ipv4_destination <= 32'(random_bits(32));
        ipv4_identification <= 16'(random_bits(16));
        udp_source <= 16'(random_bits(16));
        udp_destination <= 16'(random_bits(16));
        udp_payload_size <= 16'(1 + random_bits(6) % 40);
    endtask

    // Big-endian field into the expected header
    task automatic put_field(input logic [47:0] value, input int count);
        for (int index = count - 1; index >= 0; index--) begin
            expected_header[header_fill] = value[8*index +: 8];
            header_fill++;
        end
    endtask

    task automatic check_frame();
        int          data_bytes;
        logic [31:0] word_sum;
        logic [31:0] crc;
        logic [7:0]  expected_byte;
        data_bytes = (expected_payload_size < 16'(MIN_UDP_DATA_BYTES)) ? MIN_UDP_DATA_BYTES
                                                                       : int'(expected_payload_size);
        check_value(frame_length, HEADER_BYTES + data_bytes + FCS_BYTES, "frame length");
        if (frame_length == HEADER_BYTES + data_bytes + FCS_BYTES) begin
            header_fill = 0;
            put_field(expected_mac_destination, 6);
            put_field(expected_mac_source, 6);
            put_field(48'(ETHERTYPE_IPV4), 2);
            put_field(48'({IPV4_VERSION_IHL, IPV4_DSCP}), 2);
            put_field(48'(expected_payload_size + 16'(IPV4_HEADER_BYTES + UDP_HEADER_BYTES)), 2);
            put_field(48'(expected_ipv4_identification), 2);
            put_field(48'(0), 2);
            put_field(48'({IPV4_TIME_TO_LIVE, IPV4_PROTOCOL_UDP}), 2);
            put_field(48'(0), 2);
            put_field(48'(expected_ipv4_source), 4);
            put_field(48'(expected_ipv4_destination), 4);
            put_field(48'(expected_udp_source), 2);
            put_field(48'(expected_udp_destination), 2);
            put_field(48'(expected_payload_size + 16'(UDP_HEADER_BYTES)), 2);
            put_field(48'(0), 2);
            for (int index = 0; index < HEADER_BYTES; index++) begin
                if (index != CHECKSUM_OFFSET && index != CHECKSUM_OFFSET + 1) begin
                    check_value(32'(frame_bytes[index]), 32'(expected_header[index]),
                                $sformatf("header byte %0d", index));
                end
            end

            // Header summed with its own checksum folds to all ones
            word_sum = 0;
            for (int index = 0; index < IPV4_HEADER_BYTES; index += 2) begin
                word_sum += {16'h0, frame_bytes[MAC_HEADER_BYTES + index],
                             frame_bytes[MAC_HEADER_BYTES + index + 1]};
            end
            word_sum = {16'h0, word_sum[15:0]} + {16'h0, word_sum[31:16]};
            word_sum = {16'h0, word_sum[15:0]} + {16'h0, word_sum[31:16]};
            check_value(32'(word_sum[15:0]), 32'hFFFF, "IPv4 header one's-complement sum");

            for (int index = 0; index < data_bytes; index++) begin
                expected_byte = (index < int'(expected_payload_size)) ? buffer_byte(16'(index)) : 8'h00;
                check_value(32'(frame_bytes[HEADER_BYTES + index]), 32'(expected_byte),
                            $sformatf("data byte %0d", index));
            end

            crc = CRC32_INITIAL;
            for (int index = 0; index < HEADER_BYTES + data_bytes; index++) begin
                crc = crc32_update(crc, frame_bytes[index]);
            end
            crc = ~crc;
            for (int index = 0; index < FCS_BYTES; index++) begin
                check_value(32'(frame_bytes[HEADER_BYTES + data_bytes + index]),
                            32'(crc[8*index +: 8]), $sformatf("FCS byte %0d", index));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Buffer model, acceptance and capture
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        udp_buffer_read_data <= buffer_byte(udp_buffer_read_address);
    end

    always @(posedge clock) begin
        if (reset_n && ready && enable) begin
            expected_mac_destination = mac_destination;
            expected_mac_source = mac_source;
            expected_ipv4_source = ipv4_source;
            expected_ipv4_destination = ipv4_destination;
            expected_ipv4_identification = ipv4_identification;
            expected_udp_source = udp_source;
            expected_udp_destination = udp_destination;
            expected_payload_size = udp_payload_size;
            accept_cycle = cycle_count;
            accepted_count++;
            if (accepted_count == FRAME_COUNT) begin
                enable <= 1'b0;
            end
            draw_fields();
        end
    end

    always @(posedge clock) begin
        if (reset_n && frame_valid) begin
            if (frame_start) begin
                check_value(cycle_count - accept_cycle, START_DELAY_CYCLES,
                            "cycles from acceptance to frame_start");
                frame_length = 0;
            end
            if (frame_length < MAX_FRAME_BYTES) begin
                frame_bytes[frame_length] = frame_data;
            end
            frame_length++;
            if (frame_last) begin
                check_frame();
                frames_checked++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d frames checked",
                     cycle_count, frames_checked, FRAME_COUNT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        @(posedge clock);
        repeat (3) begin
            @(posedge clock);
            check_value(32'({frame_valid, frame_start, frame_last, ready}), 32'd0,
                        "frame strobes and ready in reset");
            check_value(32'(udp_buffer_read_address), 32'd0, "read address in reset");
        end
        reset_n <= 1'b1;
        enable <= 1'b1;
        draw_fields();
        @(posedge clock);
        check_value(32'(ready), 32'd0, "ready at the edge releasing reset");
        @(posedge clock);
        check_value(32'(ready), 32'd1, "ready after reset release");

        // Enable stays high, so frames run back to back
        wait (frames_checked == FRAME_COUNT);
        while (!ready) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);

        $display("Frames checked %0d of %0d, check errors %0d, property failures %0d",
                 frames_checked, FRAME_COUNT, error_count,
                 udp_frame_generator_i.udp_frame_generator_properties_i.failure_count);
        if (error_count == 0
            && udp_frame_generator_i.udp_frame_generator_properties_i.failure_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/ethernet_pkg.sv
design/ipv4_udp_pkg.sv
design/ipv4_header_checksum.sv
design/frame_sequencer.sv
design/frame_check_sequence.sv
design/udp_frame_generator.sv
testbench/udp_frame_generator_properties.sv
testbench/udp_frame_generator_tb.sv

// ==== Bender.yml ====
package:
  name: udp_frame_generator

sources:
  - design/ethernet_pkg.sv
  - design/ipv4_udp_pkg.sv
  - design/ipv4_header_checksum.sv
  - design/frame_sequencer.sv
  - design/frame_check_sequence.sv
  - design/udp_frame_generator.sv
  - target: test
    files:
      - testbench/udp_frame_generator_properties.sv
      - testbench/udp_frame_generator_tb.sv
